/* logic/fsctl_pkg.sv */
`default_nettype none

package fsctl_pkg;

	// bus and field widths
	localparam int REG_IDX_W  = 8;
	localparam int DATA_W     = 32;
	localparam int IMG_W_BITS = 12;
	localparam int IMG_H_BITS = 12;
	localparam int SPEED_W    = 16;
	localparam int STEP_W     = 16;
	localparam int MS_W       = 3;

	localparam logic [DATA_W-1:0] CORE_VERSION = 32'h0102_0300;

	// ----------------------------------------------
	// register word indices
	// ----------------------------------------------
	typedef enum logic [REG_IDX_W-1:0] {
		REG_ST_INT_EN     = 0,
		REG_ST_INT_STATE  = 1,
		REG_ST_RAW        = 2,
		REG_DISP_CFGING   = 3,
		REG_ST_SEL        = 4,
		REG_ST_SOFT_RST   = 5,
		REG_ST_DST_BMP    = 6,
		REG_ST_SIZE       = 7,
		REG_ST_WIN_POS    = 8,
		REG_ST_WIN_SIZE   = 9,
		REG_ST_DST_POS    = 10,
		REG_ST_DST_SIZE   = 11,
		REG_MT_EN_RST     = 32,
		REG_MT_INT_EN     = 33,
		REG_MT_INT_STATE  = 34,
		REG_MT_RAW        = 35,
		REG_MT_START_STOP = 36,
		REG_MT_MS         = 37,
		REG_MT_DIR        = 38,
		// per-motor blocks, motor index added to the base
		REG_MT_STROKE     = 39,
		REG_MT_STEP       = 47,
		REG_MT_SPEED      = 55,
		REG_SOFT_RST      = 254,
		REG_VERSION       = 255
	} reg_addr_e;

endpackage

`default_nettype wire

/* logic/wb_reg_port.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_reg_port
	import fsctl_pkg::*;
(
	input  wire                  o_clk,
	input  wire                  o_resetn,
	input  wire                  i_wb_cyc,
	input  wire                  i_wb_stb,
	input  wire                  i_wb_we,
	input  wire [REG_IDX_W-1:0]  i_wb_adr,
	input  wire [DATA_W-1:0]     i_wb_dat,
	input  wire [DATA_W-1:0]     i_rd_data,
	output logic [DATA_W-1:0]    o_wb_dat,
	output logic                 o_wb_ack,
	output logic                 o_reg_wr,
	output reg_addr_e            o_reg_addr,
	output logic [DATA_W-1:0]    o_reg_wdata,
	output logic                 o_soft_resetn
);

	logic              req;
	reg_addr_e         addr_q;
	logic [DATA_W-1:0] local_rd;

	assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;

	// live bus address for the read, latched copy while ack and the write strobe are out
	assign o_reg_addr = o_wb_ack ? addr_q : reg_addr_e'(i_wb_adr);

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_wb_ack <= 1'b0;
			o_reg_wr <= 1'b0;
		end else begin
			o_wb_ack <= req;
			o_reg_wr <= req && i_wb_we;
		end
	end

	always_ff @(posedge o_clk) begin
		if (req) begin
			addr_q      <= reg_addr_e'(i_wb_adr);
			o_reg_wdata <= i_wb_dat;
			o_wb_dat    <= i_rd_data | local_rd;
		end
	end

	// ----------------------------------------------
	// global registers
	// ----------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn)
			o_soft_resetn <= 1'b0;
		else if (o_reg_wr && o_reg_addr == REG_SOFT_RST)
			o_soft_resetn <= o_reg_wdata[0];
	end

	always_comb begin
		case (o_reg_addr)
			REG_SOFT_RST: local_rd = DATA_W'(o_soft_resetn);
			REG_VERSION:  local_rd = CORE_VERSION;
			default:      local_rd = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/frame_sync.sv */
`default_nettype none
`timescale 1ns/1ps

module frame_sync (
	input  wire  o_clk,
	input  wire  o_resetn,
	input  wire  i_fsync,
	input  wire  i_disp_cfging,
	output logic o_update,
	output logic o_fsync,
	output logic o_out_ce
);

	logic fsync_d1;
	logic fsync_d2;
	logic fsync_d3;
	logic fsync_rise;
	logic rise_q;

	// d1/d2 synchronise, d3 holds the previous level
	assign fsync_rise = fsync_d2 && !fsync_d3;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_d1 <= 1'b0;
			fsync_d2 <= 1'b0;
			fsync_d3 <= 1'b0;
			rise_q   <= 1'b0;
			o_update <= 1'b0;
			o_fsync  <= 1'b0;
			o_out_ce <= 1'b0;
		end else begin
			fsync_d1 <= i_fsync;
			fsync_d2 <= fsync_d1;
			fsync_d3 <= fsync_d2;
			rise_q   <= fsync_rise;
			// host still writing the display config, hold the live copy
			o_update <= fsync_rise && !i_disp_cfging;
			o_fsync  <= rise_q;
			o_out_ce <= o_out_ce || rise_q;
		end
	end

endmodule

`default_nettype wire

/* logic/stream_cfg.sv */
`default_nettype none
`timescale 1ns/1ps

module stream_cfg
	import fsctl_pkg::*;
#(
	parameter int STREAM_NBR = 2
) (
	input  wire                                   o_clk,
	input  wire                                   o_resetn,
	input  wire                                   i_reg_wr,
	input  reg_addr_e                             i_reg_addr,
	input  wire [DATA_W-1:0]                      i_reg_wdata,
	input  wire                                   i_update,
	output logic [DATA_W-1:0]                     o_rd_data,
	output logic                                  o_disp_cfging,
	output logic [STREAM_NBR-1:0]                 o_soft_resetn,
	output logic [STREAM_NBR-1:0][STREAM_NBR-1:0] o_dst_bmp,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_width,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_height,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_win_left,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_win_top,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_win_width,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_win_height,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_dst_left,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_dst_top,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_dst_width,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_dst_height
);

	// regs 7..11 each hold a {w/left, h/top} pair
	localparam int GEO_W = IMG_W_BITS + IMG_H_BITS;
	localparam int GEO_N = 5;

	logic [STREAM_NBR-1:0]                       st_sel;
	logic [STREAM_NBR-1:0]                       stg_soft_resetn;
	logic [STREAM_NBR-1:0][STREAM_NBR-1:0]       stg_dst_bmp;
	logic [STREAM_NBR-1:0][GEO_N-1:0][GEO_W-1:0] stg_geo;
	logic [STREAM_NBR-1:0][GEO_N-1:0][GEO_W-1:0] live_geo;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_disp_cfging <= 1'b0;
			st_sel        <= '0;
		end else if (i_reg_wr) begin
			if (i_reg_addr == REG_DISP_CFGING)
				o_disp_cfging <= i_reg_wdata[0];
			if (i_reg_addr == REG_ST_SEL)
				st_sel <= i_reg_wdata[STREAM_NBR-1:0];
		end
	end

	// ----------------------------------------------
	// staged copy, one write lands in every selected stream
	// ----------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			stg_soft_resetn <= '0;
			stg_dst_bmp     <= '0;
			stg_geo         <= '0;
		end else if (i_reg_wr) begin
			for (int s = 0; s < STREAM_NBR; s++) begin
				if (st_sel[s]) begin
					if (i_reg_addr == REG_ST_SOFT_RST)
						stg_soft_resetn[s] <= i_reg_wdata[0];
					if (i_reg_addr == REG_ST_DST_BMP)
						stg_dst_bmp[s] <= i_reg_wdata[STREAM_NBR-1:0];
					for (int k = 0; k < GEO_N; k++) begin
						if (i_reg_addr == reg_addr_e'(REG_ST_SIZE + k))
							stg_geo[s][k] <= {i_reg_wdata[16 +: IMG_W_BITS],
							                  i_reg_wdata[0 +: IMG_H_BITS]};
					end
				end
			end
		end
	end

	// live copy moves only on the frame update
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_soft_resetn <= '0;
			o_dst_bmp     <= '0;
			live_geo      <= '0;
		end else if (i_update) begin
			for (int s = 0; s < STREAM_NBR; s++) begin
				if (st_sel[s]) begin
					o_soft_resetn[s] <= stg_soft_resetn[s];
					o_dst_bmp[s]     <= stg_dst_bmp[s];
					live_geo[s]      <= stg_geo[s];
				end
			end
		end
	end

	for (genvar s = 0; s < STREAM_NBR; s++) begin : g_out
		assign o_height[s]     = live_geo[s][0][0 +: IMG_H_BITS];
		assign o_width[s]      = live_geo[s][0][IMG_H_BITS +: IMG_W_BITS];
		assign o_win_top[s]    = live_geo[s][1][0 +: IMG_H_BITS];
		assign o_win_left[s]   = live_geo[s][1][IMG_H_BITS +: IMG_W_BITS];
		assign o_win_height[s] = live_geo[s][2][0 +: IMG_H_BITS];
		assign o_win_width[s]  = live_geo[s][2][IMG_H_BITS +: IMG_W_BITS];
		assign o_dst_top[s]    = live_geo[s][3][0 +: IMG_H_BITS];
		assign o_dst_left[s]   = live_geo[s][3][IMG_H_BITS +: IMG_W_BITS];
		assign o_dst_height[s] = live_geo[s][4][0 +: IMG_H_BITS];
		assign o_dst_width[s]  = live_geo[s][4][IMG_H_BITS +: IMG_W_BITS];
	end

	always_comb begin
		case (i_reg_addr)
			REG_DISP_CFGING: o_rd_data = DATA_W'(o_disp_cfging);
			REG_ST_SEL:      o_rd_data = DATA_W'(st_sel);
			default:         o_rd_data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/irq_bank.sv */
`default_nettype none
`timescale 1ns/1ps

module irq_bank
	import fsctl_pkg::*;
#(
	parameter int               N_SRC      = 2,
	parameter logic [N_SRC-1:0] TRIG_POL   = '1,
	parameter reg_addr_e        EN_ADDR    = REG_ST_INT_EN,
	parameter reg_addr_e        STATE_ADDR = REG_ST_INT_STATE,
	parameter reg_addr_e        RAW_ADDR   = REG_ST_RAW
) (
	input  wire               o_clk,
	input  wire               o_resetn,
	input  wire               i_reg_wr,
	input  reg_addr_e         i_reg_addr,
	input  wire [DATA_W-1:0]  i_reg_wdata,
	input  wire [N_SRC-1:0]   i_src,
	input  wire               i_irq_chain,
	output logic [DATA_W-1:0] o_rd_data,
	output logic              o_irq
);

	logic [N_SRC-1:0] src_q;
	logic [N_SRC-1:0] trig;
	logic [N_SRC-1:0] clr;
	logic [N_SRC-1:0] int_en;
	logic [N_SRC-1:0] int_state;

	// pol 1 catches rising edges, pol 0 falling
	assign trig = (TRIG_POL & i_src & ~src_q) | (~TRIG_POL & ~i_src & src_q);
	assign clr  = (i_reg_wr && i_reg_addr == STATE_ADDR) ? i_reg_wdata[N_SRC-1:0] : '0;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			src_q     <= '0;
			int_en    <= '0;
			int_state <= '0;
		end else begin
			src_q <= i_src;
			if (i_reg_wr && i_reg_addr == EN_ADDR)
				int_en <= i_reg_wdata[N_SRC-1:0];
			// a new event beats a clear in the same cycle
			int_state <= (int_state & ~clr) | trig;
		end
	end

	assign o_irq = i_irq_chain || (|(int_en & int_state));

	always_comb begin
		case (i_reg_addr)
			EN_ADDR:    o_rd_data = DATA_W'(int_en);
			STATE_ADDR: o_rd_data = DATA_W'(int_state);
			RAW_ADDR:   o_rd_data = DATA_W'(i_src);
			default:    o_rd_data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* logic/motor_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module motor_ctrl
	import fsctl_pkg::*;
#(
	parameter int MOTOR_NBR = 2
) (
	input  wire                               o_clk,
	input  wire                               o_resetn,
	input  wire                               i_reg_wr,
	input  reg_addr_e                         i_reg_addr,
	input  wire [DATA_W-1:0]                  i_reg_wdata,
	output logic [DATA_W-1:0]                 o_rd_data,
	output logic [MOTOR_NBR-1:0]              o_xen,
	output logic [MOTOR_NBR-1:0]              o_xrst,
	output logic [MOTOR_NBR-1:0]              o_start,
	output logic [MOTOR_NBR-1:0]              o_stop,
	output logic [MOTOR_NBR-1:0][MS_W-1:0]    o_ms,
	output logic [MOTOR_NBR-1:0]              o_dir,
	output logic [MOTOR_NBR-1:0][STEP_W-1:0]  o_stroke,
	output logic [MOTOR_NBR-1:0][STEP_W-1:0]  o_step,
	output logic [MOTOR_NBR-1:0][SPEED_W-1:0] o_speed
);

	// ----------------------------------------------
	// shared regs use a 4-bit lane per motor
	// ----------------------------------------------
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_xen    <= '0;
			o_xrst   <= '0;
			o_start  <= '0;
			o_stop   <= '0;
			o_ms     <= '0;
			o_dir    <= '0;
			o_stroke <= '0;
			o_step   <= '0;
			o_speed  <= '0;
		end else begin
			// start/stop are single-cycle pulses
			o_start <= '0;
			o_stop  <= '0;
			if (i_reg_wr) begin
				for (int m = 0; m < MOTOR_NBR; m++) begin
					case (i_reg_addr)
						REG_MT_EN_RST: begin
							o_xen[m]  <= i_reg_wdata[4*m];
							o_xrst[m] <= i_reg_wdata[4*m+1];
						end
						REG_MT_START_STOP: begin
							o_start[m] <= i_reg_wdata[4*m];
							o_stop[m]  <= i_reg_wdata[4*m+1];
						end
						REG_MT_MS:  o_ms[m]  <= i_reg_wdata[4*m +: MS_W];
						REG_MT_DIR: o_dir[m] <= i_reg_wdata[4*m];
						default: ;
					endcase
					if (i_reg_addr == reg_addr_e'(REG_MT_STROKE + m))
						o_stroke[m] <= i_reg_wdata[STEP_W-1:0];
					if (i_reg_addr == reg_addr_e'(REG_MT_STEP + m))
						o_step[m] <= i_reg_wdata[STEP_W-1:0];
					if (i_reg_addr == reg_addr_e'(REG_MT_SPEED + m))
						o_speed[m] <= i_reg_wdata[SPEED_W-1:0];
				end
			end
		end
	end

	// start/stop not stored, reads back zero
	always_comb begin
		o_rd_data = '0;
		for (int m = 0; m < MOTOR_NBR; m++) begin
			case (i_reg_addr)
				REG_MT_EN_RST: begin
					o_rd_data[4*m]   = o_xen[m];
					o_rd_data[4*m+1] = o_xrst[m];
				end
				REG_MT_MS:  o_rd_data[4*m +: MS_W] = o_ms[m];
				REG_MT_DIR: o_rd_data[4*m] = o_dir[m];
				default: ;
			endcase
			if (i_reg_addr == reg_addr_e'(REG_MT_STROKE + m))
				o_rd_data[STEP_W-1:0] = o_stroke[m];
			if (i_reg_addr == reg_addr_e'(REG_MT_STEP + m))
				o_rd_data[STEP_W-1:0] = o_step[m];
			if (i_reg_addr == reg_addr_e'(REG_MT_SPEED + m))
				o_rd_data[SPEED_W-1:0] = o_speed[m];
		end
	end

endmodule

`default_nettype wire

/* logic/fsctl_top.sv */
`default_nettype none
`timescale 1ns/1ps

module fsctl_top
	import fsctl_pkg::*;
#(
	parameter int STREAM_NBR = 2,
	parameter int MOTOR_NBR  = 2
) (
	input  wire                                   o_clk,
	input  wire                                   o_resetn,
	input  wire                                   i_wb_cyc,
	input  wire                                   i_wb_stb,
	input  wire                                   i_wb_we,
	input  wire [REG_IDX_W-1:0]                   i_wb_adr,
	input  wire [DATA_W-1:0]                      i_wb_dat,
	output logic [DATA_W-1:0]                     o_wb_dat,
	output logic                                  o_wb_ack,
	input  wire                                   i_fsync,
	output logic                                  o_fsync,
	output logic                                  o_out_ce,
	output logic                                  o_intr,
	output logic                                  o_soft_resetn,
	// streams
	input  wire [STREAM_NBR-1:0]                  i_wr_done,
	output logic [STREAM_NBR-1:0]                 o_st_soft_resetn,
	output logic [STREAM_NBR-1:0][STREAM_NBR-1:0] o_dst_bmp,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_width,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_height,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_win_left,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_win_top,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_win_width,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_win_height,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_dst_left,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_dst_top,
	output logic [STREAM_NBR-1:0][IMG_W_BITS-1:0] o_dst_width,
	output logic [STREAM_NBR-1:0][IMG_H_BITS-1:0] o_dst_height,
	// motors
	input  wire [MOTOR_NBR-1:0]                   i_zpsign,
	input  wire [MOTOR_NBR-1:0]                   i_tpsign,
	input  wire [MOTOR_NBR-1:0]                   i_mt_state,
	output logic [MOTOR_NBR-1:0]                  o_xen,
	output logic [MOTOR_NBR-1:0]                  o_xrst,
	output logic [MOTOR_NBR-1:0]                  o_start,
	output logic [MOTOR_NBR-1:0]                  o_stop,
	output logic [MOTOR_NBR-1:0][MS_W-1:0]        o_ms,
	output logic [MOTOR_NBR-1:0]                  o_dir,
	output logic [MOTOR_NBR-1:0][STEP_W-1:0]      o_stroke,
	output logic [MOTOR_NBR-1:0][STEP_W-1:0]      o_step,
	output logic [MOTOR_NBR-1:0][SPEED_W-1:0]     o_speed
);

	logic                     reg_wr;
	reg_addr_e                reg_addr;
	logic [DATA_W-1:0]        reg_wdata;
	logic [DATA_W-1:0]        rd_data;
	logic [DATA_W-1:0]        st_rd;
	logic [DATA_W-1:0]        st_irq_rd;
	logic [DATA_W-1:0]        mt_irq_rd;
	logic [DATA_W-1:0]        mt_rd;
	logic                     update;
	logic                     disp_cfging;
	logic                     st_irq;
	logic [3*MOTOR_NBR-1:0]   mt_src;

	// peers return zero off their own addresses
	assign rd_data = st_rd | st_irq_rd | mt_irq_rd | mt_rd;

	// three event lines per motor: zpsign, tpsign, state
	for (genvar m = 0; m < MOTOR_NBR; m++) begin : g_mt_src
		assign mt_src[3*m]   = i_zpsign[m];
		assign mt_src[3*m+1] = i_tpsign[m];
		assign mt_src[3*m+2] = i_mt_state[m];
	end

	wb_reg_port u_port (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .i_rd_data(rd_data),
		.o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.o_reg_wr(reg_wr), .o_reg_addr(reg_addr), .o_reg_wdata(reg_wdata),
		.o_soft_resetn(o_soft_resetn)
	);

	frame_sync u_fsync (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_fsync(i_fsync), .i_disp_cfging(disp_cfging),
		.o_update(update), .o_fsync(o_fsync), .o_out_ce(o_out_ce)
	);

	stream_cfg #(.STREAM_NBR(STREAM_NBR)) u_stream (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_reg_wr(reg_wr), .i_reg_addr(reg_addr), .i_reg_wdata(reg_wdata),
		.i_update(update), .o_rd_data(st_rd), .o_disp_cfging(disp_cfging),
		.o_soft_resetn(o_st_soft_resetn), .o_dst_bmp(o_dst_bmp),
		.o_width(o_width), .o_height(o_height),
		.o_win_left(o_win_left), .o_win_top(o_win_top),
		.o_win_width(o_win_width), .o_win_height(o_win_height),
		.o_dst_left(o_dst_left), .o_dst_top(o_dst_top),
		.o_dst_width(o_dst_width), .o_dst_height(o_dst_height)
	);

	irq_bank #(
		.N_SRC(STREAM_NBR), .TRIG_POL({STREAM_NBR{1'b1}}),
		.EN_ADDR(REG_ST_INT_EN), .STATE_ADDR(REG_ST_INT_STATE), .RAW_ADDR(REG_ST_RAW)
	) u_st_irq (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_reg_wr(reg_wr), .i_reg_addr(reg_addr), .i_reg_wdata(reg_wdata),
		.i_src(i_wr_done), .i_irq_chain(1'b0),
		.o_rd_data(st_irq_rd), .o_irq(st_irq)
	);

	// motor state interrupts on its falling edge
	irq_bank #(
		.N_SRC(3*MOTOR_NBR), .TRIG_POL({MOTOR_NBR{3'b011}}),
		.EN_ADDR(REG_MT_INT_EN), .STATE_ADDR(REG_MT_INT_STATE), .RAW_ADDR(REG_MT_RAW)
	) u_mt_irq (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_reg_wr(reg_wr), .i_reg_addr(reg_addr), .i_reg_wdata(reg_wdata),
		.i_src(mt_src), .i_irq_chain(st_irq),
		.o_rd_data(mt_irq_rd), .o_irq(o_intr)
	);

	motor_ctrl #(.MOTOR_NBR(MOTOR_NBR)) u_motor (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_reg_wr(reg_wr), .i_reg_addr(reg_addr), .i_reg_wdata(reg_wdata),
		.o_rd_data(mt_rd), .o_xen(o_xen), .o_xrst(o_xrst),
		.o_start(o_start), .o_stop(o_stop), .o_ms(o_ms), .o_dir(o_dir),
		.o_stroke(o_stroke), .o_step(o_step), .o_speed(o_speed)
	);

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_resetn
);

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// 16 cycles of reset, released on a falling edge
	initial begin
		o_resetn = 1'b0;
		repeat (16) @(posedge o_clk);
		@(negedge o_clk);
		o_resetn = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/fsctl_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module fsctl_tb
	import fsctl_pkg::*;
();

	localparam int ST_N    = 2;
	localparam int MT_N    = 2;
	localparam int TIMEOUT = 100;

	logic o_clk;
	logic o_resetn;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [REG_IDX_W-1:0] i_wb_adr;
	logic [DATA_W-1:0] i_wb_dat;
	logic [DATA_W-1:0] o_wb_dat;
	logic o_wb_ack;
	logic i_fsync;
	logic o_fsync;
	logic o_out_ce;
	logic o_intr;
	logic o_soft_resetn;
	logic [ST_N-1:0] i_wr_done;
	logic [ST_N-1:0] o_st_soft_resetn;
	logic [ST_N-1:0][ST_N-1:0] o_dst_bmp;
	logic [ST_N-1:0][IMG_W_BITS-1:0] o_width, o_win_left, o_win_width, o_dst_left, o_dst_width;
	logic [ST_N-1:0][IMG_H_BITS-1:0] o_height, o_win_top, o_win_height, o_dst_top, o_dst_height;
	logic [MT_N-1:0] i_zpsign;
	logic [MT_N-1:0] i_tpsign;
	logic [MT_N-1:0] i_mt_state;
	logic [MT_N-1:0] o_xen, o_xrst, o_start, o_stop, o_dir;
	logic [MT_N-1:0][MS_W-1:0] o_ms;
	logic [MT_N-1:0][STEP_W-1:0] o_stroke, o_step;
	logic [MT_N-1:0][SPEED_W-1:0] o_speed;

	// expected model where stream regs 5..11 map to slots 0..6
	logic [31:0] shadow [0:255];
	logic [ST_N-1:0] sel_m;
	logic [ST_N-1:0][6:0][31:0] stg_m;
	logic [ST_N-1:0][6:0][31:0] live_m;
	logic [ST_N-1:0][6:0][31:0] cfg_out;
	logic [31:0] lfsr_state;

	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	string what_q [$];
	event check_ev;
	logic [31:0] cmp_got;
	logic [31:0] cmp_exp;
	string cmp_what;
	int checks = 0;
	int errors = 0;

	tb_clk_gen u_clk (.o_clk(o_clk), .o_resetn(o_resetn));

	fsctl_top #(.STREAM_NBR(ST_N), .MOTOR_NBR(MT_N)) DUT (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
		.i_fsync(i_fsync), .o_fsync(o_fsync), .o_out_ce(o_out_ce), .o_intr(o_intr),
		.o_soft_resetn(o_soft_resetn), .i_wr_done(i_wr_done),
		.o_st_soft_resetn(o_st_soft_resetn), .o_dst_bmp(o_dst_bmp),
		.o_width(o_width), .o_height(o_height), .o_win_left(o_win_left),
		.o_win_top(o_win_top), .o_win_width(o_win_width), .o_win_height(o_win_height),
		.o_dst_left(o_dst_left), .o_dst_top(o_dst_top), .o_dst_width(o_dst_width),
		.o_dst_height(o_dst_height), .i_zpsign(i_zpsign), .i_tpsign(i_tpsign),
		.i_mt_state(i_mt_state), .o_xen(o_xen), .o_xrst(o_xrst), .o_start(o_start),
		.o_stop(o_stop), .o_ms(o_ms), .o_dir(o_dir), .o_stroke(o_stroke),
		.o_step(o_step), .o_speed(o_speed)
	);

	always_comb begin
		for (int s = 0; s < ST_N; s++) begin
			cfg_out[s][0] = 32'(o_st_soft_resetn[s]);
			cfg_out[s][1] = 32'(o_dst_bmp[s]);
			cfg_out[s][2] = 32'({o_width[s], o_height[s]});
			cfg_out[s][3] = 32'({o_win_left[s], o_win_top[s]});
			cfg_out[s][4] = 32'({o_win_width[s], o_win_height[s]});
			cfg_out[s][5] = 32'({o_dst_left[s], o_dst_top[s]});
			cfg_out[s][6] = 32'({o_dst_width[s], o_dst_height[s]});
		end
	end

	// ----------------------------------------------
	// reference model and random source
	// ----------------------------------------------
	function automatic logic [31:0] expected_read(input int addr, input logic [31:0] w);
		logic [31:0] mask;
		mask = '0;
		for (int m = 0; m < MT_N; m++) begin
			if (addr == REG_MT_EN_RST)
				mask[4*m +: 2] = 2'b11;
			if (addr == REG_MT_MS)
				mask[4*m +: MS_W] = '1;
			if (addr == REG_MT_DIR)
				mask[4*m] = 1'b1;
			if (addr == REG_MT_STROKE + m || addr == REG_MT_STEP + m)
				mask[STEP_W-1:0] = '1;
			if (addr == REG_MT_SPEED + m)
				mask[SPEED_W-1:0] = '1;
		end
		if (addr == REG_ST_INT_EN || addr == REG_ST_SEL)
			mask[ST_N-1:0] = '1;
		if (addr == REG_MT_INT_EN)
			mask[3*MT_N-1:0] = '1;
		if (addr == REG_DISP_CFGING || addr == REG_SOFT_RST)
			mask[0] = 1'b1;
		return w & mask;
	endfunction

	function automatic logic [31:0] cfg_field(input int addr, input logic [31:0] w);
		if (addr == REG_ST_SOFT_RST)
			return 32'(w[0]);
		if (addr == REG_ST_DST_BMP)
			return 32'(w[ST_N-1:0]);
		return 32'({w[16 +: IMG_W_BITS], w[0 +: IMG_H_BITS]});
	endfunction

	function automatic int motor_addr(input int i);
		if (i == 0)
			return REG_MT_EN_RST;
		if (i < 3)
			return REG_MT_MS + i - 1;
		return REG_MT_STROKE + 8 * ((i - 3) / MT_N) + (i - 3) % MT_N;
	endfunction

	// fibonacci with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		got_q.push_back(got);
		exp_q.push_back(exp);
		what_q.push_back(what);
		-> check_ev;
	endtask

	always begin
		@(check_ev);
		while (got_q.size() != 0) begin
			cmp_got  = got_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_what = what_q.pop_front();
			checks++;
			if (cmp_got !== cmp_exp) begin
				errors++;
				$display("Fail at %0t: %s, got %h expected %h", $time, cmp_what, cmp_got,
					cmp_exp);
			end
		end
	end

	// ----------------------------------------------
	// bus and frame tasks start and end on a falling edge
	// ----------------------------------------------
	task automatic bus_cycle(input logic we, input int addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		i_wb_we  = we;
		i_wb_adr = addr[REG_IDX_W-1:0];
		i_wb_dat = wdata;
		n = 0;
		@(negedge o_clk);
		while (!o_wb_ack && n < TIMEOUT) begin
			n++;
			@(negedge o_clk);
		end
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we  = 1'b0;
		if (!o_wb_ack) begin
			$display("no ack from bus cycle at register %0d", addr);
			$display("Simulation failed");
			$finish;
		end else begin
			rdata = o_wb_dat;
		end
	endtask

	task automatic write_reg(input int addr, input logic [31:0] w);
		logic [31:0] ack_data;
		bus_cycle(1'b1, addr, w, ack_data);
		shadow[addr] = w;
		if (addr == REG_ST_SEL)
			sel_m = w[ST_N-1:0];
		if (addr >= REG_ST_SOFT_RST && addr <= REG_ST_DST_SIZE) begin
			for (int s = 0; s < ST_N; s++) begin
				if (sel_m[s])
					stg_m[s][addr - REG_ST_SOFT_RST] = cfg_field(addr, w);
			end
		end
	endtask

	task automatic check_read(input int addr, input logic [31:0] exp, input string what);
		logic [31:0] r;
		bus_cycle(1'b0, addr, '0, r);
		expect_value(r, exp, $sformatf("%s, register %0d", what, addr));
	endtask

	task automatic check_streams(input string when);
		for (int s = 0; s < ST_N; s++) begin
			for (int j = 0; j < 7; j++)
				expect_value(cfg_out[s][j], live_m[s][j],
					$sformatf("%s, stream %0d field of register %0d", when, s, j + 5));
		end
	endtask

	task automatic check_motor_outputs();
		for (int m = 0; m < MT_N; m++) begin
			expect_value(o_xen[m], shadow[REG_MT_EN_RST][4*m], $sformatf("xen %0d", m));
			expect_value(o_xrst[m], shadow[REG_MT_EN_RST][4*m+1], $sformatf("xrst %0d", m));
			expect_value(o_ms[m], shadow[REG_MT_MS][4*m +: MS_W], $sformatf("ms %0d", m));
			expect_value(o_dir[m], shadow[REG_MT_DIR][4*m], $sformatf("dir %0d", m));
			expect_value(o_stroke[m], shadow[REG_MT_STROKE + m][STEP_W-1:0], "stroke");
			expect_value(o_step[m], shadow[REG_MT_STEP + m][STEP_W-1:0], "step");
			expect_value(o_speed[m], shadow[REG_MT_SPEED + m][SPEED_W-1:0], "speed");
		end
	endtask

	task automatic run_frame(input logic applies);
		int n;
		i_fsync = 1'b1;
		n = 0;
		@(negedge o_clk);
		while (!o_fsync && n < TIMEOUT) begin
			check_streams("before o_fsync");
			n++;
			@(negedge o_clk);
		end
		if (!o_fsync) begin
			$display("o_fsync never pulsed after i_fsync rose");
			$display("Simulation failed");
			$finish;
		end else begin
			// two sync stages, edge detect, then the output edge
			expect_value(n, 3, "o_fsync latency in cycles");
			if (applies) begin
				for (int s = 0; s < ST_N; s++) begin
					if (sel_m[s])
						live_m[s] = stg_m[s];
				end
			end
			check_streams("at o_fsync");
			i_fsync = 1'b0;
			@(negedge o_clk);
			expect_value(o_fsync, 1'b0, "o_fsync one cycle wide");
			expect_value(o_out_ce, 1'b1, "o_out_ce after o_fsync");
			// synchroniser drains before the next rise
			repeat (4) @(negedge o_clk);
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (!o_resetn && n < TIMEOUT) begin
			n++;
			@(negedge o_clk);
		end
		if (!o_resetn) begin
			$display("reset was never released");
			$display("Simulation failed");
			$finish;
		end
	endtask

	// ----------------------------------------------
	// test sequence
	// ----------------------------------------------
	initial begin
		logic [31:0] w;
		logic [MT_N-1:0] exp_start;
		logic [MT_N-1:0] exp_stop;
		i_wb_cyc   = 1'b0;
		i_wb_stb   = 1'b0;
		i_wb_we    = 1'b0;
		i_wb_adr   = '0;
		i_wb_dat   = '0;
		i_fsync    = 1'b0;
		i_wr_done  = '0;
		i_zpsign   = '0;
		i_tpsign   = '0;
		i_mt_state = '0;
		lfsr_state = 32'h7671_de65;
		sel_m      = '0;
		stg_m      = '0;
		live_m     = '0;
		for (int a = 0; a < 256; a++)
			shadow[a] = '0;
		wait_reset_release();

		// reset state
		for (int a = 0; a < 255; a++)
			check_read(a, 32'h0, "reset value");
		check_read(REG_VERSION, CORE_VERSION, "version");
		expect_value(o_fsync, 1'b0, "o_fsync after reset");
		expect_value(o_out_ce, 1'b0, "o_out_ce after reset");
		expect_value(o_intr, 1'b0, "o_intr after reset");
		expect_value(o_soft_resetn, 1'b0, "o_soft_resetn after reset");
		check_streams("after reset");
		check_motor_outputs();

		// motor registers
		for (int it = 0; it < 4; it++) begin
			for (int i = 0; i < 3 + 3 * MT_N; i++) begin
				rand_bits(32, w);
				write_reg(motor_addr(i), w);
				@(negedge o_clk);
				check_motor_outputs();
				check_read(motor_addr(i), expected_read(motor_addr(i), w), "motor readback");
			end
		end
		rand_bits(32, w);
		w[0] = 1'b1;
		for (int m = 0; m < MT_N; m++) begin
			exp_start[m] = w[4*m];
			exp_stop[m]  = w[4*m+1];
		end
		write_reg(REG_MT_START_STOP, w);
		@(negedge o_clk);
		expect_value(o_start, exp_start, "start pulse");
		expect_value(o_stop, exp_stop, "stop pulse");
		@(negedge o_clk);
		expect_value({o_start, o_stop}, 32'h0, "start/stop after one cycle");
		check_read(REG_MT_START_STOP, 32'h0, "start/stop readback");
		write_reg(REG_SOFT_RST, 32'h1);
		@(negedge o_clk);
		expect_value(o_soft_resetn, 1'b1, "o_soft_resetn set");
		check_read(REG_SOFT_RST, expected_read(REG_SOFT_RST, 32'h1), "soft reset readback");

		// all streams staged but only one selected at each frame
		for (int ph = 0; ph < ST_N; ph++) begin
			write_reg(REG_ST_SEL, (32'h1 << ST_N) - 1);
			for (int r = REG_ST_SOFT_RST; r <= REG_ST_DST_SIZE; r++) begin
				rand_bits(32, w);
				write_reg(r, w);
			end
			write_reg(REG_ST_SEL, 32'h1 << ph);
			check_read(REG_ST_SEL, expected_read(REG_ST_SEL, 32'h1 << ph), "stream select");
			run_frame(1'b1);
		end

		// display configuring holds the live copy
		write_reg(REG_DISP_CFGING, 32'h1);
		check_read(REG_DISP_CFGING, 32'h1, "display configuring");
		for (int r = REG_ST_SOFT_RST; r <= REG_ST_DST_SIZE; r++) begin
			rand_bits(32, w);
			write_reg(r, w);
		end
		run_frame(1'b0);
		write_reg(REG_DISP_CFGING, 32'h0);
		run_frame(1'b1);

		// stream interrupts
		write_reg(REG_ST_INT_EN, 32'h1);
		i_wr_done[0] = 1'b1;
		@(negedge o_clk);
		expect_value(o_intr, 1'b1, "o_intr on wr_done 0");
		i_wr_done[1] = 1'b1;
		@(negedge o_clk);
		check_read(REG_ST_INT_STATE, 32'h3, "stream irq state");
		check_read(REG_ST_RAW, 32'h3, "stream raw");
		write_reg(REG_ST_INT_STATE, 32'h1);
		@(negedge o_clk);
		expect_value(o_intr, 1'b0, "o_intr after clear");
		check_read(REG_ST_INT_STATE, 32'h2, "stream irq state after clear");
		write_reg(REG_ST_INT_STATE, 32'h2);

		// motor interrupts with zpsign of motor 0 and state of the last motor enabled
		write_reg(REG_MT_INT_EN, (32'h1 << 0) | (32'h1 << (3*(MT_N-1)+2)));
		i_mt_state[MT_N-1] = 1'b1;
		@(negedge o_clk);
		expect_value(o_intr, 1'b0, "o_intr on state rise");
		i_mt_state[MT_N-1] = 1'b0;
		i_zpsign[MT_N-1]   = 1'b1;
		@(negedge o_clk);
		expect_value(o_intr, 1'b1, "o_intr on state fall");
		check_read(REG_MT_INT_STATE, (32'h1 << (3*(MT_N-1)+2)) | (32'h1 << (3*(MT_N-1))),
			"motor irq state");
		check_read(REG_MT_RAW, 32'h1 << (3*(MT_N-1)), "motor raw");
		write_reg(REG_MT_INT_STATE, 32'h1 << (3*(MT_N-1)+2));
		@(negedge o_clk);
		expect_value(o_intr, 1'b0, "o_intr after motor clear");
		i_zpsign[0] = 1'b1;
		@(negedge o_clk);
		expect_value(o_intr, 1'b1, "o_intr on zpsign 0");
		write_reg(REG_MT_INT_STATE, 32'hffff_ffff);
		@(negedge o_clk);
		expect_value(o_intr, 1'b0, "o_intr after clearing all");
		check_read(REG_MT_INT_STATE, 32'h0, "motor irq state cleared");

		@(negedge o_clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* fsctl_top.f */
logic/fsctl_pkg.sv
logic/wb_reg_port.sv
logic/frame_sync.sv
logic/stream_cfg.sv
logic/irq_bank.sv
logic/motor_ctrl.sv
logic/fsctl_top.sv
verif/tb_clk_gen.sv
verif/fsctl_tb.sv
